//--- design/bank_arbiter.sv
// Fixed-priority arbiter for one SDRAM bank port.
// The lowest slot index with req high wins while the bank is idle, and the
// grant holds from the bank request until rdy, so there is one access in
// flight. The bank request is registered and drops on ack.
// ack, rdy and data_read go back to the granted slot only.
`timescale 1ns/1ps

module bank_arbiter import sdram_pkg::*; #(
    parameter int N = 1
) (
    input  logic        clk,
    input  logic        arst_n,
    bank_req_if.arbiter slots [N],
    output sdram_addr_t sdram_addr,
    output logic        sdram_rd,
    output logic        sdram_wr,
    output word_t       sdram_din,
    output wrmask_t     sdram_wrmask,
    input  logic        sdram_ack,
    input  logic        sdram_rdy,
    input  word_t       data_read
);

    localparam int GW = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0]  req_vec;
    logic [N-1:0]  wr_vec;
    sdram_addr_t   addr_arr [N];
    word_t         din_arr  [N];
    wrmask_t       mask_arr [N];
    logic [GW-1:0] pick;
    logic [GW-1:0] grant;
    logic          busy;
    logic          start;

    for (genvar i = 0; i < N; i++) begin : g_slot
        assign req_vec[i]  = slots[i].req;
        assign wr_vec[i]   = slots[i].wr;
        assign addr_arr[i] = slots[i].addr;
        assign din_arr[i]  = slots[i].din;
        assign mask_arr[i] = slots[i].wrmask;

        assign slots[i].ack  = sdram_ack && (sdram_rd || sdram_wr) && (grant == GW'(i));
        assign slots[i].rdy  = sdram_rdy && busy && (grant == GW'(i));
        assign slots[i].data = (grant == GW'(i)) ? data_read : '0;
    end

    always_comb begin
        pick = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (req_vec[i]) pick = GW'(i);  // Lowest index wins
        end
    end

    assign start = !busy && (|req_vec);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            grant    <= '0;
            sdram_rd <= 1'b0;
            sdram_wr <= 1'b0;
        end else if (start) begin
            busy     <= 1'b1;
            grant    <= pick;
            sdram_rd <= !wr_vec[pick];
            sdram_wr <= wr_vec[pick];
        end else if (busy) begin
            if (sdram_ack) begin
                sdram_rd <= 1'b0;
                sdram_wr <= 1'b0;
            end
            if (sdram_rdy) busy <= 1'b0;  // Bank free for the next request
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr   <= addr_arr[pick];
            sdram_din    <= din_arr[pick];
            sdram_wrmask <= mask_arr[pick];
        end
    end

endmodule

//--- design/bank_req_if.sv
// Request channel between one client slot and its bank arbiter.
// The slot holds req with addr, wr, din and wrmask steady until ack.
// ack pulses when the bank takes the request, rdy pulses once data is valid
// or the write has completed. No new req is raised before rdy.
`timescale 1ns/1ps

interface bank_req_if import sdram_pkg::*; ();

    logic        req;
    sdram_addr_t addr;
    logic        wr;
    word_t       din;
    wrmask_t     wrmask;   // Active low

    logic        ack;
    logic        rdy;
    word_t       data;

    modport slot (
        output req, addr, wr, din, wrmask,
        input  ack, rdy, data
    );

    modport arbiter (
        input  req, addr, wr, din, wrmask,
        output ack, rdy, data
    );

endinterface

//--- design/mem_slot.sv
// Client slot in front of one bank arbiter.
// Maps the client address into its SDRAM region and keeps the last word read,
// so a repeated address is answered without a bank access.
// Byte clients get the high byte when the address low bit is set.
// WRITABLE=0 gives a read-only slot with the write fields held idle.
`timescale 1ns/1ps

module mem_slot import sdram_pkg::*; #(
    parameter type         payload_t = word_t,
    parameter sdram_addr_t OFFSET    = '0,
    parameter int          AW        = 16,
    parameter bit          WRITABLE  = 1'b0
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    input  logic          rnw,
    input  payload_t      din,
    input  wrmask_t       dsn,
    output logic          ok,
    output payload_t      dout,
    bank_req_if.slot      bus
);

    localparam bit IS_BYTE = ($bits(payload_t) == 8);

    sdram_addr_t   word_addr;
    word_t         din_word;
    sdram_addr_t   cache_addr;
    word_t         cache_word;
    logic          cache_valid;
    logic          busy;        // Request out, waiting for rdy
    logic [AW-1:0] last_addr;
    logic          last_rnw;
    logic          is_write;
    logic          hit;
    logic          addr_moved;

    if (IS_BYTE) begin : g_byte
        assign word_addr = OFFSET + sdram_addr_t'(addr[AW-1:1]);
        assign din_word  = {din, din};
        assign dout      = payload_t'(addr[0] ? cache_word[15:8] : cache_word[7:0]);
    end else begin : g_word
        assign word_addr = OFFSET + sdram_addr_t'(addr);
        assign din_word  = word_t'(din);
        assign dout      = payload_t'(cache_word);
    end

    assign is_write   = WRITABLE && !rnw;
    assign hit        = cache_valid && (cache_addr == word_addr) && !is_write;
    assign addr_moved = (addr != last_addr) || (rnw != last_rnw);

    assign bus.addr   = word_addr;
    assign bus.wr     = is_write;
    assign bus.din    = WRITABLE ? din_word : '0;
    assign bus.wrmask = WRITABLE ? dsn : '1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.req     <= 1'b0;
            busy        <= 1'b0;
            ok          <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            if (bus.ack) bus.req <= 1'b0;
            if (bus.rdy) begin
                busy <= 1'b0;
                ok   <= 1'b1;   // Data lands in the cache on this edge
                if (!is_write) cache_valid <= 1'b1;
            end else if (!cs || (ok && addr_moved)) begin
                ok <= 1'b0;
            end else if (!ok && !busy) begin
                if (hit) begin
                    ok <= 1'b1;  // Served locally
                end else begin
                    bus.req <= 1'b1;
                    busy    <= 1'b1;
                end
            end
        end
    end

    // Cached word and the client access being answered
    always_ff @(posedge clk) begin
        if (!ok) begin
            last_addr <= addr;
            last_rnw  <= rnw;
        end
        if (bus.rdy) begin
            if (!is_write) begin
                cache_addr <= word_addr;
                cache_word <= bus.data;
            end else if (cache_valid && cache_addr == word_addr) begin
                if (!dsn[1]) cache_word[15:8] <= din_word[15:8];
                if (!dsn[0]) cache_word[7:0]  <= din_word[7:0];
            end
        end
    end

endmodule

//--- design/sdram_banks.sv
// Top level of the SDRAM bank slot subsystem.
// Bank 0 (read/write) serves work RAM, program ROM and sound ROM in that
// priority order. Bank 1 (read only) serves the graphics ROM.
// Each client uses a cs level and waits for ok before changing its address.
`timescale 1ns/1ps

module sdram_banks import sdram_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    // Main CPU work RAM
    input  logic              main_ram_cs,
    input  logic [RAM_AW-1:0] main_ram_addr,
    input  logic              main_rnw,
    input  word_t             main_dout,
    input  wrmask_t           dsn,
    output logic              main_ram_ok,
    output word_t             main_ram_data,
    // Main CPU program ROM
    input  logic              main_rom_cs,
    input  logic [ROM_AW-1:0] main_rom_addr,
    output logic              main_rom_ok,
    output word_t             main_rom_data,
    // Sound CPU ROM, byte wide
    input  logic              snd_cs,
    input  logic [SND_AW-1:0] snd_addr,
    output logic              snd_ok,
    output byte_t             snd_data,
    // Graphics ROM
    input  logic              gfx_cs,
    input  logic [GFX_AW-1:0] gfx_addr,
    output logic              gfx_ok,
    output word_t             gfx_data,
    // Bank 0
    output sdram_addr_t       ba0_addr,
    output logic              ba0_rd,
    output logic              ba0_wr,
    output word_t             ba0_din,
    output wrmask_t           ba0_din_m,
    input  logic              ba0_ack,
    input  logic              ba0_rdy,
    // Bank 1
    output sdram_addr_t       ba1_addr,
    output logic              ba1_rd,
    input  logic              ba1_ack,
    input  logic              ba1_rdy,
    input  word_t             data_read
);

    bank_req_if b0_req [BANK0_SLOTS] ();
    bank_req_if b1_req [BANK1_SLOTS] ();

    mem_slot #(.payload_t(word_t), .OFFSET(RAM_OFFSET), .AW(RAM_AW), .WRITABLE(1'b1)) i_ram_slot (
        .clk(clk), .arst_n(arst_n), .cs(main_ram_cs), .addr(main_ram_addr), .rnw(main_rnw),
        .din(main_dout), .dsn(dsn), .ok(main_ram_ok), .dout(main_ram_data),
        .bus(b0_req[SLOT_RAM])
    );

    mem_slot #(.payload_t(word_t), .OFFSET(ROM_OFFSET), .AW(ROM_AW)) i_rom_slot (
        .clk(clk), .arst_n(arst_n), .cs(main_rom_cs), .addr(main_rom_addr), .rnw(1'b1),
        .din('0), .dsn(2'b11), .ok(main_rom_ok), .dout(main_rom_data),
        .bus(b0_req[SLOT_ROM])
    );

    mem_slot #(.payload_t(byte_t), .OFFSET(SND_OFFSET), .AW(SND_AW)) i_snd_slot (
        .clk(clk), .arst_n(arst_n), .cs(snd_cs), .addr(snd_addr), .rnw(1'b1),
        .din('0), .dsn(2'b11), .ok(snd_ok), .dout(snd_data),
        .bus(b0_req[SLOT_SND])
    );

    mem_slot #(.payload_t(word_t), .OFFSET(GFX_OFFSET), .AW(GFX_AW)) i_gfx_slot (
        .clk(clk), .arst_n(arst_n), .cs(gfx_cs), .addr(gfx_addr), .rnw(1'b1),
        .din('0), .dsn(2'b11), .ok(gfx_ok), .dout(gfx_data),
        .bus(b1_req[SLOT_GFX])
    );

    bank_arbiter #(.N(BANK0_SLOTS)) i_bank0_arb (
        .clk(clk), .arst_n(arst_n), .slots(b0_req),
        .sdram_addr(ba0_addr), .sdram_rd(ba0_rd), .sdram_wr(ba0_wr),
        .sdram_din(ba0_din), .sdram_wrmask(ba0_din_m),
        .sdram_ack(ba0_ack), .sdram_rdy(ba0_rdy), .data_read(data_read)
    );

    // Read-only bank, write fields left open
    bank_arbiter #(.N(BANK1_SLOTS)) i_bank1_arb (
        .clk(clk), .arst_n(arst_n), .slots(b1_req),
        .sdram_addr(ba1_addr), .sdram_rd(ba1_rd), .sdram_wr(),
        .sdram_din(), .sdram_wrmask(),
        .sdram_ack(ba1_ack), .sdram_rdy(ba1_rdy), .data_read(data_read)
    );

endmodule

//--- design/sdram_pkg.sv
// Shared widths, types and SDRAM region map for the bank slot subsystem.
// Imported by the slots, the arbiters, the request interface and the top level.
// Offsets and address widths are in SDRAM words unless noted otherwise.
package sdram_pkg;

    localparam int SDRAM_AW = 23;  // Word address into one bank
    localparam int SDRAM_DW = 16;

    typedef logic [SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [SDRAM_DW-1:0] word_t;
    typedef logic [7:0]          byte_t;

    // One bit per byte, low means the byte is written
    typedef logic [SDRAM_DW/8-1:0] wrmask_t;

    // Bank 0 region map
    localparam sdram_addr_t ROM_OFFSET = 23'h00_0000;
    localparam sdram_addr_t RAM_OFFSET = 23'h30_0000;
    localparam sdram_addr_t SND_OFFSET = 23'h38_0000;

    // Bank 1 holds graphics only
    localparam sdram_addr_t GFX_OFFSET = 23'h00_0000;

    // Slot indexes on bank 0 set the priority order
    localparam int BANK0_SLOTS = 3;
    localparam int SLOT_RAM    = 0;
    localparam int SLOT_ROM    = 1;
    localparam int SLOT_SND    = 2;

    localparam int BANK1_SLOTS = 1;
    localparam int SLOT_GFX    = 0;

    // Client address widths
    localparam int RAM_AW = 17;  // 16-bit words
    localparam int ROM_AW = 20;  // 16-bit words
    localparam int SND_AW = 16;  // Bytes
    localparam int GFX_AW = 21;  // 16-bit words

endpackage

//--- src.f
design/sdram_pkg.sv
design/bank_req_if.sv
design/mem_slot.sv
design/bank_arbiter.sv
design/sdram_banks.sv
testbench/sdram_bank_model.sv
testbench/sdram_banks_asserts.sv
testbench/tb_sdram_banks.sv

//--- testbench/sdram_bank_model.sv
// Behavioral SDRAM bank for the testbench.
// Takes one request at a time, pulses ack 1 to 3 cycles later and rdy two
// cycles after ack. Unwritten words read as a fill pattern of their address.
// yield_rdy holds rdy back a cycle so two banks never return data together.
`timescale 1ns/1ps

module sdram_bank_model import sdram_pkg::*; #(
    parameter word_t FILL = 16'h5A5A
) (
    input  logic        clk,
    input  logic        arst_n,
    input  sdram_addr_t addr,
    input  logic        rd,
    input  logic        wr,
    input  word_t       din,
    input  wrmask_t     din_m,      // Active low
    input  logic        yield_rdy,
    output logic        ack,
    output logic        rdy,
    output word_t       dout,
    output logic        rdy_due     // rdy is due at the coming falling edge
);

    word_t       mem [sdram_addr_t];  // Written words only
    integer      seed = 9;
    int          ack_cnt;
    int          rdy_cnt;
    sdram_addr_t req_addr;

    // Upper address bits folded in so the regions read differently
    function automatic word_t word_at(sdram_addr_t a);
        if (mem.exists(a)) return mem[a];
        return a[15:0] ^ {9'd0, a[22:16]} ^ FILL;
    endfunction

    function automatic word_t merged(word_t old, word_t d, wrmask_t m);
        return {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
    endfunction

    assign rdy_due = (rdy_cnt == 1);

    always @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack     <= 1'b0;
            rdy     <= 1'b0;
            dout    <= '0;
            ack_cnt <= 0;
            rdy_cnt <= 0;
        end else begin
            ack <= 1'b0;
            rdy <= 1'b0;
            if (ack_cnt != 0) begin
                ack     <= (ack_cnt == 1);
                rdy_cnt <= (ack_cnt == 1) ? 2 : 0;
                ack_cnt <= ack_cnt - 1;
            end else if (rdy_cnt > 1) begin
                rdy_cnt <= rdy_cnt - 1;
            end else if (rdy_cnt == 1 && !yield_rdy) begin
                rdy     <= 1'b1;
                dout    <= word_at(req_addr);
                rdy_cnt <= 0;
            end else if (rdy_cnt == 0 && (rd || wr)) begin
                req_addr <= addr;
                ack_cnt  <= 1 + ($unsigned($random(seed)) % 3);
                if (wr) mem[addr] = merged(word_at(addr), din, din_m);
            end
        end
    end

endmodule

//--- testbench/sdram_banks_asserts.sv
// Protocol checks bound into the subsystem top level.
// Covers rd/wr exclusion on bank 0 with writes kept to the work RAM region,
// bank requests held steady until ack, and every ok flag dropping one cycle
// after its cs.
// fail_count counts failed checks and is read by the testbench.
`timescale 1ns/1ps

module sdram_banks_asserts import sdram_pkg::*; (
    input logic        clk,
    input logic        arst_n,
    input logic        ba0_rd,
    input logic        ba0_wr,
    input logic        ba0_ack,
    input sdram_addr_t ba0_addr,
    input word_t       ba0_din,
    input wrmask_t     ba0_din_m,
    input logic        ba1_rd,
    input logic        ba1_ack,
    input sdram_addr_t ba1_addr,
    input logic [3:0]  cs,          // RAM, ROM, sound, graphics from bit 0
    input logic [3:0]  ok
);

    int fail_count = 0;

    function void note_failure(string what);
        $error("%s", what);
        fail_count++;
    endfunction

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(ba0_rd && ba0_wr) &&
        (!ba0_wr || (ba0_addr >= RAM_OFFSET && ba0_addr < RAM_OFFSET + (1 << RAM_AW))))
        else note_failure("ba0_rd and ba0_wr high together or write outside work RAM");

    a_ba0_steady: assert property (@(posedge clk) disable iff (!arst_n)
        (ba0_rd || ba0_wr) && !ba0_ack |=> $stable({ba0_rd, ba0_wr, ba0_addr, ba0_din, ba0_din_m}))
        else note_failure("bank 0 request changed before ack");

    a_ba1_steady: assert property (@(posedge clk) disable iff (!arst_n)
        ba1_rd && !ba1_ack |=> ba1_rd && $stable(ba1_addr))
        else note_failure("bank 1 request changed before ack");

    for (genvar i = 0; i < 4; i++) begin : g_ok
        a_ok_drop: assert property (@(posedge clk) disable iff (!arst_n) !cs[i] |=> !ok[i])
            else note_failure("ok still high one cycle after cs fell");
    end

endmodule

bind sdram_banks sdram_banks_asserts i_asserts (
    .clk, .arst_n, .ba0_rd, .ba0_wr, .ba0_ack, .ba0_addr, .ba0_din, .ba0_din_m,
    .ba1_rd, .ba1_ack, .ba1_addr,
    .cs({gfx_cs, snd_cs, main_rom_cs, main_ram_cs}),
    .ok({gfx_ok, snd_ok, main_rom_ok, main_ram_ok})
);

//--- testbench/tb_sdram_banks.sv
// Directed testbench for the SDRAM bank slot subsystem.
// Two behavioral banks answer with random latency. Client ports are driven
// on the falling edge; data, cache hit timing and bank 0 order are checked.
`timescale 1ns/1ps

module tb_sdram_banks import sdram_pkg::*; ();

    localparam int    PERIOD   = 4;
    localparam int    ACCESSES = 12;       // Client accesses over all tests
    localparam word_t FILL0    = 16'h5A5A;
    localparam word_t FILL1    = 16'hA5A5;

    logic clk = 1'b0;
    logic arst_n;
    logic main_ram_cs, main_rnw, main_ram_ok, main_rom_cs, main_rom_ok;
    logic snd_cs, snd_ok, gfx_cs, gfx_ok;
    logic [RAM_AW-1:0] main_ram_addr;
    logic [ROM_AW-1:0] main_rom_addr;
    logic [SND_AW-1:0] snd_addr;
    logic [GFX_AW-1:0] gfx_addr;
    word_t       main_dout, main_ram_data, main_rom_data, gfx_data;
    byte_t       snd_data;
    wrmask_t     dsn, ba0_din_m;
    sdram_addr_t ba0_addr, ba1_addr;
    logic        ba0_rd, ba0_wr, ba0_ack, ba0_rdy, ba1_rd, ba1_ack, ba1_rdy, b0_rdy_due;
    word_t       ba0_din, data_read, b0_data, b1_data;
    sdram_addr_t addr_log [$];              // Bank 0 addresses in accept order

    sdram_banks i_sdram_banks (.*);

    sdram_bank_model #(.FILL(FILL0)) i_bank0 (
        .clk, .arst_n, .addr(ba0_addr), .rd(ba0_rd), .wr(ba0_wr), .din(ba0_din),
        .din_m(ba0_din_m), .yield_rdy(1'b0), .ack(ba0_ack), .rdy(ba0_rdy),
        .dout(b0_data), .rdy_due(b0_rdy_due)
    );
    // Bank 1 gives way to bank 0 on the shared data_read
    sdram_bank_model #(.FILL(FILL1)) i_bank1 (
        .clk, .arst_n, .addr(ba1_addr), .rd(ba1_rd), .wr(1'b0), .din('0),
        .din_m('1), .yield_rdy(b0_rdy_due), .ack(ba1_ack), .rdy(ba1_rdy),
        .dout(b1_data), .rdy_due()
    );
    assign data_read = ba0_rdy ? b0_data : b1_data;

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (ba0_ack && (ba0_rd || ba0_wr)) addr_log.push_back(ba0_addr);
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_run($sformatf("Error at %0t ns: %s = 0x%h, expected 0x%h",
                               $time, name, got, exp));
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
            fail_run($sformatf("Error at %0t ns: %s = 0x%h, expected 0x%h",
                               $time, name, got, exp));
    endtask

    task automatic check_addr(input string name, input sdram_addr_t got, input sdram_addr_t exp);
        if (got !== exp)
            fail_run($sformatf("Error at %0t ns: %s = 0x%h, expected 0x%h",
                               $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    endtask

    // Expected bank contents, upper address bits folded in
    function automatic word_t fill(sdram_addr_t a, word_t pattern);
        return a[15:0] ^ {9'd0, a[22:16]} ^ pattern;
    endfunction

    task automatic ram_access(input logic rnw, input logic [RAM_AW-1:0] a, input word_t d,
                              input wrmask_t m, output word_t q);
        @(negedge clk);
        main_ram_cs   = 1'b1;
        main_ram_addr = a;
        main_rnw      = rnw;
        main_dout     = d;
        dsn           = m;
        do @(negedge clk); while (!main_ram_ok);
        q           = main_ram_data;
        main_ram_cs = 1'b0;
        main_rnw    = 1'b1;
        @(negedge clk);
    endtask

    task automatic rom_read(input logic [ROM_AW-1:0] a, output word_t q);
        @(negedge clk);
        main_rom_cs   = 1'b1;
        main_rom_addr = a;
        do @(negedge clk); while (!main_rom_ok);
        q           = main_rom_data;
        main_rom_cs = 1'b0;
        @(negedge clk);
    endtask

    task automatic snd_read(input logic [SND_AW-1:0] a, output byte_t q);
        @(negedge clk);
        snd_cs   = 1'b1;
        snd_addr = a;
        do @(negedge clk); while (!snd_ok);
        q      = snd_data;
        snd_cs = 1'b0;
        @(negedge clk);
    endtask

    task automatic gfx_read(input logic [GFX_AW-1:0] a, output word_t q);
        @(negedge clk);
        gfx_cs   = 1'b1;
        gfx_addr = a;
        do @(negedge clk); while (!gfx_ok);
        q      = gfx_data;
        gfx_cs = 1'b0;
        @(negedge clk);
    endtask

    task automatic test_rom_read();
        word_t q;
        rom_read(20'h0_0ABC, q);
        check_word("main_rom_data", q, fill(ROM_OFFSET + 23'h0_0ABC, FILL0));
    endtask

    task automatic test_snd_bytes();
        byte_t lo;
        byte_t hi;
        word_t w;
        w = fill(SND_OFFSET + 23'h800, FILL0);  // Byte address 0x1000 halved
        snd_read(16'h1000, lo);
        snd_read(16'h1001, hi);
        check_byte("snd_data", lo, w[7:0]);
        check_byte("snd_data", hi, w[15:8]);
    endtask

    task automatic test_ram_write_back();
        word_t old;
        word_t q;
        old = fill(RAM_OFFSET + 23'h40, FILL0);
        ram_access(1'b0, 17'h0_0040, 16'hC33C, 2'b10, q);   // High byte masked
        ram_access(1'b1, 17'h0_0041, '0, 2'b11, q);
        check_word("main_ram_data", q, fill(RAM_OFFSET + 23'h41, FILL0));
        ram_access(1'b1, 17'h0_0040, '0, 2'b11, q);
        check_word("main_ram_data", q, {old[15:8], 8'h3C});
    endtask

    task automatic test_cache_hit();
        word_t first;
        word_t exp;
        exp = fill(ROM_OFFSET + 23'h1234, FILL0);
        rom_read(20'h0_1234, first);
        check_word("main_rom_data", first, exp);
        main_rom_cs   = 1'b1;
        main_rom_addr = 20'h0_1234;
        @(negedge clk);
        check_bit("main_rom_ok", main_rom_ok, 1'b1);
        check_bit("ba0_rd", ba0_rd, 1'b0);
        check_word("main_rom_data", main_rom_data, exp);
        main_rom_cs = 1'b0;
        @(negedge clk);
        check_bit("ba0_rd", ba0_rd, 1'b0);
    endtask

    task automatic test_priority();
        word_t ram_q;
        word_t rom_q;
        word_t gfx_q;
        byte_t snd_q;
        addr_log.delete();
        fork
            ram_access(1'b1, 17'h0_0200, '0, 2'b11, ram_q);
            rom_read(20'h0_5678, rom_q);
            snd_read(16'h4321, snd_q);
            gfx_read(21'h1_2345, gfx_q);
        join
        check_word("main_ram_data", ram_q, fill(RAM_OFFSET + 23'h200, FILL0));
        check_word("main_rom_data", rom_q, fill(ROM_OFFSET + 23'h5678, FILL0));
        check_byte("snd_data", snd_q, byte_t'(fill(SND_OFFSET + 23'h2190, FILL0) >> 8));
        check_word("gfx_data", gfx_q, fill(GFX_OFFSET + 23'h1_2345, FILL1));
        if (addr_log.size() != 3) fail_run("Bank 0 did not accept exactly three requests");
        check_addr("ba0_addr", addr_log[0], RAM_OFFSET + 23'h200);
        check_addr("ba0_addr", addr_log[1], ROM_OFFSET + 23'h5678);
        check_addr("ba0_addr", addr_log[2], SND_OFFSET + 23'h2190);
    endtask

    initial begin
        #((ACCESSES * 40 + 10) * PERIOD);   // 40 cycles per access plus reset
        fail_run("Watchdog expired, the run timed out");
    end

    initial begin
        arst_n = 1'b0;
        {main_ram_cs, main_rom_cs, snd_cs, gfx_cs} = '0;
        {main_ram_addr, main_rom_addr, snd_addr, gfx_addr} = '0;
        main_rnw  = 1'b1;
        main_dout = '0;
        dsn       = 2'b11;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_rom_read();
        test_snd_bytes();
        test_ram_write_back();
        test_cache_hit();
        test_priority();
        if (i_sdram_banks.i_asserts.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_run("Bound protocol assertions failed during the run");
        end
    end

endmodule
